// ==== project.f ====
verilog/str_link_pkg.sv
verilog/uart_byte_if.sv
verilog/uart_tx_phy.sv
verilog/uart_rx_phy.sv
verilog/rx_msg_buf.sv
verilog/frame_ctrl.sv
verilog/str_link_top.sv
tb/str_link_asserts.sv
tb/str_link_tb.sv

// ==== tb/str_link_tb.sv ====
/*
 * str_link_tb
 * random framed traffic through the string link: loopback transmit, line
 * format, receive framing errors, overflow and credit flow
 */
`timescale 1ns/10ps

module str_link_tb;

	localparam int CLKS_PER_BIT = 8;
	localparam int MAX_LEN      = 16;
	localparam int RX_CREDITS   = 2;
	localparam int N_LOOP       = 6;
	// upper bound of bytes on both lines over the whole run
	localparam int RUN_BYTES    = N_LOOP * (MAX_LEN + 4) + 12 * (MAX_LEN + 6);
	localparam str_link_pkg::byte_t DLM = str_link_pkg::DELIM_CHAR;

	logic                 sys_clk;
	logic                 sys_rst_n;
	logic [MAX_LEN*8-1:0] tx_string;
	logic [7:0]           tx_length;
	logic                 tx_req;
	logic                 tx_busy;
	logic                 tx_done;
	logic [MAX_LEN*8-1:0] rx_string;
	logic [7:0]           rx_length;
	logic                 rx_done;
	logic                 rx_drop;
	logic                 rx_credit;
	logic                 uart_tx_port;
	logic                 ser_line;
	logic                 loopback;

	// reference model of the deframer and the host credits
	str_link_pkg::byte_t  m_buf [MAX_LEN];
	int                   m_state;
	int                   m_len;
	int                   m_credits;
	int                   exp_len_q [$];
	logic [MAX_LEN*8-1:0] exp_str_q [$];
	str_link_pkg::byte_t  exp_tx_q [$];

	logic [31:0] rng;
	int          errors;
	int          checks;
	int          test_num;
	int          test_base;
	int          owed;
	int          tx_done_cnt;
	int          drop_cnt;
	int          last_len;

	str_link_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MAX_LEN      (MAX_LEN),
		.RX_CREDITS   (RX_CREDITS)
	) u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_done      (rx_done),
		.rx_drop      (rx_drop),
		.rx_credit    (rx_credit),
		.uart_rx_port (loopback ? uart_tx_port : ser_line),
		.uart_tx_port (uart_tx_port)
	);

	initial sys_clk = 1'b0;
	always #20 sys_clk = ~sys_clk;

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("[ERROR] %0t ns %s", $time, msg);
			errors++;
		end
	endtask

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// any payload character except the delimiter
	function automatic str_link_pkg::byte_t rand_char();
		logic [31:0] r;
		r = next_rand();
		return (r[7:0] == DLM) ? 8'h7e : r[7:0];
	endfunction

	// two & open, & & closes, a lone &, a bad stop bit or overflow aborts
	task automatic model_byte(input str_link_pkg::byte_t b, input bit ferr);
		logic [MAX_LEN*8-1:0] s;
		s = '0;
		if (ferr) begin
			m_state = 0;
		end else if (m_state == 0) begin
			m_state = (b == DLM) ? 1 : 0;
		end else if (m_state == 1) begin
			m_state = (b == DLM) ? 2 : 0;
			m_len   = 0;
		end else if (m_state == 2) begin
			if (b == DLM) begin
				m_state = 3;
			end else if (m_len == MAX_LEN) begin
				m_state = 0;
			end else begin
				m_buf[m_len] = b;
				m_len++;
			end
		end else begin
			if (b == DLM) begin
				for (int i = 0; i < m_len; i++) begin
					s[i*8 +: 8] = m_buf[i];
				end
				exp_len_q.push_back(m_len);
				exp_str_q.push_back(s);
			end
			m_state = 0;
		end
	endtask

	// one character on the receive line, LSB first
	task automatic ser_byte(input str_link_pkg::byte_t b, input bit stop_ok);
		logic [9:0] bits;
		bits = {stop_ok, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			ser_line = bits[i];
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		ser_line = 1'b1;
		// idle bit so the next start bit has a falling edge
		if (!stop_ok) begin
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
		end
		model_byte(b, !stop_ok);
	endtask

	task automatic ser_frame(input int len);
		ser_byte(DLM, 1'b1);
		ser_byte(DLM, 1'b1);
		for (int i = 0; i < len; i++) begin
			ser_byte(rand_char(), 1'b1);
		end
		ser_byte(DLM, 1'b1);
		ser_byte(DLM, 1'b1);
	endtask

	task automatic wait_rx();
		int n;
		n = 0;
		while (exp_len_q.size() != 0 && n < 40 * CLKS_PER_BIT) begin
			@(negedge sys_clk);
			n++;
		end
		check(exp_len_q.size() == 0, "expected receive event did not arrive");
		repeat (4) @(negedge sys_clk);
	endtask

	task automatic pulse_credit();
		rx_credit = 1'b1;
		@(negedge sys_clk);
		rx_credit = 1'b0;
		// capped at the initial count
		if (m_credits < RX_CREDITS) begin
			m_credits++;
		end
		if (owed > 0) begin
			owed--;
		end
	endtask

	task automatic return_credits();
		while (owed > 0) begin
			repeat (1 + next_rand() % 8) @(negedge sys_clk);
			pulse_credit();
		end
	endtask

	task automatic deliver_frame(input int len);
		ser_frame(len);
		wait_rx();
		return_credits();
	endtask

	task automatic send_tx(input int len);
		logic [MAX_LEN*8-1:0] s;
		str_link_pkg::byte_t  line_q [$];
		int                   base;
		int                   n;
		s    = '0;
		base = tx_done_cnt;
		for (int i = 0; i < len; i++) begin
			s[i*8 +: 8] = rand_char();
		end
		line_q.push_back(DLM);
		line_q.push_back(DLM);
		for (int i = 0; i < len; i++) begin
			line_q.push_back(s[i*8 +: 8]);
		end
		line_q.push_back(DLM);
		line_q.push_back(DLM);
		foreach (line_q[i]) begin
			exp_tx_q.push_back(line_q[i]);
			if (loopback) begin
				model_byte(line_q[i], 1'b0);
			end
		end
		tx_string = s;
		tx_length = 8'(len);
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		// second request in the middle of the frame
		repeat (2 + next_rand() % 30) @(negedge sys_clk);
		check(tx_busy === 1'b1, "tx_busy low during a frame");
		tx_string = ~s;
		tx_length = 8'(MAX_LEN);
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		n = 0;
		while (tx_done !== 1'b1 && n < (len + 6) * 10 * CLKS_PER_BIT) begin
			@(negedge sys_clk);
			n++;
		end
		check(tx_done === 1'b1, "no tx_done within the frame time");
		repeat (4) @(negedge sys_clk);
		check(tx_done_cnt == base + 1,
			$sformatf("%0d tx_done pulses for one request", tx_done_cnt - base));
		check(exp_tx_q.size() == 0, "bytes missing on the transmit line");
		wait_rx();
		return_credits();
	endtask

	task automatic check_rx();
		int                   e_len;
		logic [MAX_LEN*8-1:0] e_str;
		if (exp_len_q.size() == 0) begin
			check(1'b0, "receive event with no matching frame on the line");
			return;
		end
		e_len = exp_len_q.pop_front();
		e_str = exp_str_q.pop_front();
		if (m_credits > 0) begin
			m_credits--;
			owed++;
			check(rx_done && !rx_drop, "rx_drop while a credit was free");
			check(rx_length == e_len,
				$sformatf("rx_length %0d, expected %0d", rx_length, e_len));
			for (int i = 0; i < e_len; i++) begin
				check(rx_string[i*8 +: 8] == e_str[i*8 +: 8],
					$sformatf("rx_string byte %0d is %02h, expected %02h",
					i, rx_string[i*8 +: 8], e_str[i*8 +: 8]));
			end
			last_len = e_len;
		end else begin
			check(rx_drop && !rx_done, "rx_done with no credit left");
			check(rx_length == last_len, "rx_length changed on a dropped frame");
		end
	endtask

	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done) begin
			tx_done_cnt++;
		end
		if (sys_rst_n && rx_drop) begin
			drop_cnt++;
		end
		if (sys_rst_n && (rx_done || rx_drop)) begin
			check_rx();
		end
	end

	// transmit line decoded on its own, sampled near each bit center
	initial begin
		str_link_pkg::byte_t b;
		str_link_pkg::byte_t e;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge uart_tx_port);
			repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
			check(uart_tx_port === 1'b0, "start bit not held low");
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				b[i] = uart_tx_port;
			end
			repeat (CLKS_PER_BIT) @(negedge sys_clk);
			check(uart_tx_port === 1'b1, "stop bit low on the transmit line");
			if (exp_tx_q.size() == 0) begin
				check(1'b0, $sformatf("unexpected byte %02h on the transmit line", b));
			end else begin
				e = exp_tx_q.pop_front();
				check(b == e, $sformatf("transmit line byte %02h, expected %02h", b, e));
			end
		end
	end

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		int drop_base;
		rng       = 32'd22299;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		rx_credit = 1'b0;
		ser_line  = 1'b1;
		loopback  = 1'b0;
		m_state   = 0;
		m_len     = 0;
		m_credits = RX_CREDITS;
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (2) @(negedge sys_clk);

		loopback = 1'b1;
		for (int i = 0; i < N_LOOP - 2; i++) begin
			send_tx((i == 0) ? 0 : ((i == 1) ? MAX_LEN : next_rand() % (MAX_LEN + 1)));
		end
		end_test("loopback transmit");

		// receive side sees an idle line here
		loopback = 1'b0;
		send_tx(next_rand() % (MAX_LEN + 1));
		send_tx(next_rand() % (MAX_LEN + 1));
		end_test("serial format");

		ser_byte(DLM, 1'b1);
		for (int i = 0; i < 3; i++) begin
			ser_byte(rand_char(), 1'b1);
		end
		deliver_frame(next_rand() % (MAX_LEN + 1));
		// & X inside the content, left without a closing pair
		ser_byte(DLM, 1'b1);
		ser_byte(DLM, 1'b1);
		ser_byte(rand_char(), 1'b1);
		ser_byte(DLM, 1'b1);
		ser_byte(8'h58, 1'b1);
		ser_byte(rand_char(), 1'b1);
		deliver_frame(next_rand() % (MAX_LEN + 1));
		// bad stop bit on the last delimiter
		ser_byte(DLM, 1'b1);
		ser_byte(DLM, 1'b1);
		ser_byte(rand_char(), 1'b1);
		ser_byte(DLM, 1'b1);
		ser_byte(DLM, 1'b0);
		deliver_frame(next_rand() % (MAX_LEN + 1));
		for (int i = 0; i < 4; i++) begin
			ser_byte(rand_char(), 1'b1);
		end
		deliver_frame(next_rand() % (MAX_LEN + 1));
		end_test("framing errors");

		// no closing pair, it would open a new frame after the abort
		ser_byte(DLM, 1'b1);
		ser_byte(DLM, 1'b1);
		for (int i = 0; i < MAX_LEN + 1; i++) begin
			ser_byte(rand_char(), 1'b1);
		end
		deliver_frame(next_rand() % (MAX_LEN + 1));
		end_test("overflow");

		drop_base = drop_cnt;
		for (int i = 0; i < 3; i++) begin
			ser_frame(1 + next_rand() % 8);
		end
		wait_rx();
		check(drop_cnt == drop_base + 1,
			$sformatf("%0d drops for three frames on two credits", drop_cnt - drop_base));
		pulse_credit();
		ser_frame(next_rand() % (MAX_LEN + 1));
		wait_rx();
		return_credits();
		// one more return than taken, the count stays at its limit
		pulse_credit();
		for (int i = 0; i < 3; i++) begin
			ser_frame(1 + next_rand() % 8);
		end
		wait_rx();
		return_credits();
		end_test("credit flow");

		errors += u_dut.u_frame_ctrl.u_asserts.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(RUN_BYTES * 10 * CLKS_PER_BIT * 40 * 2 + 200000);
		$display("watchdog expired before the tests finished");
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== tb/str_link_asserts.sv ====
/*
 * str_link_asserts
 * protocol checks on the frame controller: byte request handshake,
 * done pulse widths, credit bound and exclusive receive outcomes
 */
`timescale 1ns/10ps

module str_link_asserts #(
	parameter int RX_CREDITS = 2
) (
	input logic                              sys_clk,
	input logic                              sys_rst_n,
	input logic                              req,
	input logic                              busy,
	input logic                              tx_done,
	input logic                              rx_done,
	input logic                              rx_drop,
	input logic [$clog2(RX_CREDITS + 1)-1:0] credit_cnt
);

	// number of failed properties
	int fail_cnt;

	// byte request only toward an idle transmitter
	req_idle_phy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		req |-> !busy)
		else begin
			$error("byte request while the transmitter is busy");
			fail_cnt++;
		end

	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else begin
			$error("tx_done longer than one cycle");
			fail_cnt++;
		end

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else begin
			$error("rx_done longer than one cycle");
			fail_cnt++;
		end

	credit_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		credit_cnt <= RX_CREDITS)
		else begin
			$error("credit count above its initial value");
			fail_cnt++;
		end

	done_or_drop: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_drop))
		else begin
			$error("rx_done and rx_drop in the same cycle");
			fail_cnt++;
		end

endmodule

bind frame_ctrl str_link_asserts #(
	.RX_CREDITS (RX_CREDITS)
) u_asserts (
	.sys_clk    (sys_clk),
	.sys_rst_n  (sys_rst_n),
	.req        (byte_if.req),
	.busy       (byte_if.busy),
	.tx_done    (tx_done),
	.rx_done    (rx_done),
	.rx_drop    (rx_drop),
	.credit_cnt (credit_cnt)
);

// ==== verilog/str_link_top.sv ====
/*
 * str_link_top
 * framed string link over a UART: frame controller, both serial PHYs
 * and the receive payload buffer
 */
`timescale 1ns/10ps

module str_link_top #(
	parameter int CLKS_PER_BIT = 16,
	parameter int MAX_LEN      = 16,
	parameter int RX_CREDITS   = 2
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [MAX_LEN*8-1:0] tx_string,
	input  logic [7:0]           tx_length,
	input  logic                 tx_req,
	output logic                 tx_busy,
	output logic                 tx_done,
	output logic [MAX_LEN*8-1:0] rx_string,
	output logic [7:0]           rx_length,
	output logic                 rx_done,
	output logic                 rx_drop,
	input  logic                 rx_credit,
	input  logic                 uart_rx_port,
	output logic                 uart_tx_port
);

	str_link_pkg::byte_t rx_data;
	logic                rx_vld;
	logic                rx_ferr;
	logic                buf_clr;
	logic                buf_wr;
	str_link_pkg::byte_t buf_byte;
	logic [7:0]          buf_len;
	logic                buf_full;

	uart_byte_if byte_if ();

	frame_ctrl #(
		.MAX_LEN    (MAX_LEN),
		.RX_CREDITS (RX_CREDITS)
	) u_frame_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_if   (byte_if.ctrl),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_ferr   (rx_ferr),
		.buf_clr   (buf_clr),
		.buf_wr    (buf_wr),
		.buf_byte  (buf_byte),
		.buf_len   (buf_len),
		.buf_full  (buf_full),
		.rx_length (rx_length),
		.rx_done   (rx_done),
		.rx_drop   (rx_drop),
		.rx_credit (rx_credit)
	);

	uart_tx_phy #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_tx_phy (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_if   (byte_if.phy),
		.txd       (uart_tx_port)
	);

	uart_rx_phy #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx_phy (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.rx_ferr   (rx_ferr)
	);

	rx_msg_buf #(
		.MAX_LEN (MAX_LEN)
	) u_rx_buf (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.buf_clr   (buf_clr),
		.buf_wr    (buf_wr),
		.buf_byte  (buf_byte),
		.msg       (rx_string),
		.msg_len   (buf_len),
		.full      (buf_full)
	);

endmodule

// ==== verilog/frame_ctrl.sv ====
/*
 * frame_ctrl
 * transmit framer (&& payload &&), receive deframer with abort on a
 * lone &, framing error or overflow, and the receive credit counter
 */
`timescale 1ns/10ps

module frame_ctrl #(
	parameter int MAX_LEN    = 16,
	parameter int RX_CREDITS = 2
) (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic [MAX_LEN*8-1:0] tx_string,
	input  logic [7:0]           tx_length,
	input  logic                 tx_req,
	output logic                 tx_busy,
	output logic                 tx_done,
	uart_byte_if.ctrl            byte_if,
	input  str_link_pkg::byte_t  rx_data,
	input  logic                 rx_vld,
	input  logic                 rx_ferr,
	output logic                 buf_clr,
	output logic                 buf_wr,
	output str_link_pkg::byte_t  buf_byte,
	input  logic [7:0]           buf_len,
	input  logic                 buf_full,
	output logic [7:0]           rx_length,
	output logic                 rx_done,
	output logic                 rx_drop,
	input  logic                 rx_credit
);

	localparam int CRW = $clog2(RX_CREDITS + 1);

	str_link_pkg::tx_state_t tx_state;
	str_link_pkg::rx_state_t rx_state;
	logic [MAX_LEN*8-1:0]    str_q;
	logic [7:0]              tx_len;
	logic [7:0]              tx_idx;
	logic [CRW-1:0]          credit_cnt;
	logic                    credit_take;
	logic                    rx_delim;

	assign tx_busy = (tx_state != str_link_pkg::TX_IDLE);
	assign tx_done = (tx_state == str_link_pkg::TX_FINISH);

	// transmit framer, each byte starts on done of the one before
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state     <= str_link_pkg::TX_IDLE;
			byte_if.req  <= 1'b0;
			byte_if.data <= '0;
			tx_len       <= '0;
			tx_idx       <= '0;
		end else begin
			byte_if.req <= 1'b0;
			case (tx_state)
				str_link_pkg::TX_IDLE: begin
					if (tx_req) begin
						tx_len       <= (tx_length > MAX_LEN) ? 8'(MAX_LEN) : tx_length;
						tx_idx       <= '0;
						byte_if.data <= str_link_pkg::DELIM_CHAR;
						byte_if.req  <= 1'b1;
						tx_state     <= str_link_pkg::TX_DLM1;
					end
				end
				str_link_pkg::TX_DLM1: begin
					if (byte_if.done) begin
						byte_if.data <= str_link_pkg::DELIM_CHAR;
						byte_if.req  <= 1'b1;
						tx_state     <= str_link_pkg::TX_DLM2;
					end
				end
				// second opening & and each payload byte lead to the next byte
				str_link_pkg::TX_DLM2, str_link_pkg::TX_CONTENT: begin
					if (byte_if.done) begin
						byte_if.req <= 1'b1;
						if (tx_idx == tx_len) begin
							byte_if.data <= str_link_pkg::DELIM_CHAR;
							tx_state     <= str_link_pkg::TX_DLM3;
						end else begin
							byte_if.data <= str_q[int'(tx_idx) * 8 +: 8];
							tx_idx       <= tx_idx + 8'd1;
							tx_state     <= str_link_pkg::TX_CONTENT;
						end
					end
				end
				str_link_pkg::TX_DLM3: begin
					if (byte_if.done) begin
						byte_if.data <= str_link_pkg::DELIM_CHAR;
						byte_if.req  <= 1'b1;
						tx_state     <= str_link_pkg::TX_DLM4;
					end
				end
				str_link_pkg::TX_DLM4: begin
					if (byte_if.done) begin
						tx_state <= str_link_pkg::TX_FINISH;
					end
				end
				default: tx_state <= str_link_pkg::TX_IDLE;
			endcase
		end
	end

	// string captured with the request, later requests ignored while busy
	always_ff @(posedge sys_clk) begin
		if (tx_state == str_link_pkg::TX_IDLE && tx_req) begin
			str_q <= tx_string;
		end
	end

	assign rx_delim = (rx_data == str_link_pkg::DELIM_CHAR);
	assign buf_byte = rx_data;
	assign buf_clr  = (rx_state == str_link_pkg::RX_OPEN1) && rx_vld && rx_delim;
	assign buf_wr   = (rx_state == str_link_pkg::RX_CONTENT) && rx_vld && !rx_delim
		&& !buf_full;

	// receive deframer
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= str_link_pkg::RX_IDLE;
		end else begin
			case (rx_state)
				str_link_pkg::RX_IDLE: begin
					if (rx_vld && rx_delim) begin
						rx_state <= str_link_pkg::RX_OPEN1;
					end
				end
				str_link_pkg::RX_OPEN1: begin
					if (rx_ferr || (rx_vld && !rx_delim)) begin
						rx_state <= str_link_pkg::RX_IDLE;
					end else if (rx_vld) begin
						rx_state <= str_link_pkg::RX_CONTENT;
					end
				end
				str_link_pkg::RX_CONTENT: begin
					// overflow drops the frame without a drop pulse
					if (rx_ferr || (rx_vld && !rx_delim && buf_full)) begin
						rx_state <= str_link_pkg::RX_IDLE;
					end else if (rx_vld && rx_delim) begin
						rx_state <= str_link_pkg::RX_CLOSE1;
					end
				end
				str_link_pkg::RX_CLOSE1: begin
					if (rx_ferr || (rx_vld && !rx_delim)) begin
						rx_state <= str_link_pkg::RX_IDLE;
					end else if (rx_vld) begin
						rx_state <= str_link_pkg::RX_DELIVER;
					end
				end
				default: rx_state <= str_link_pkg::RX_IDLE;
			endcase
		end
	end

	assign credit_take = (rx_state == str_link_pkg::RX_DELIVER) && (credit_cnt != '0);

	// delivery with a credit, otherwise drop
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_done   <= 1'b0;
			rx_drop   <= 1'b0;
			rx_length <= '0;
		end else begin
			rx_done <= credit_take;
			rx_drop <= (rx_state == str_link_pkg::RX_DELIVER) && !credit_take;
			if (credit_take) begin
				rx_length <= buf_len;
			end
		end
	end

	// returned credits saturate at RX_CREDITS
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			credit_cnt <= CRW'(RX_CREDITS);
		end else if (credit_take && !rx_credit) begin
			credit_cnt <= credit_cnt - 1'b1;
		end else if (!credit_take && rx_credit && credit_cnt != CRW'(RX_CREDITS)) begin
			credit_cnt <= credit_cnt + 1'b1;
		end
	end

endmodule

// ==== verilog/rx_msg_buf.sv ====
/*
 * rx_msg_buf
 * receive payload assembly: bytes land at the write index, the index
 * doubles as the length, full warns of overflow
 */
`timescale 1ns/10ps

module rx_msg_buf #(
	parameter int MAX_LEN = 16
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   buf_clr,
	input  logic                   buf_wr,
	input  str_link_pkg::byte_t    buf_byte,
	output logic [MAX_LEN*8-1:0]   msg,
	output logic [7:0]             msg_len,
	output logic                   full
);

	// one more byte would not fit
	assign full = (msg_len == 8'(MAX_LEN));

	// write index, cleared when a frame opens
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			msg_len <= '0;
		end else if (buf_clr) begin
			msg_len <= '0;
		end else if (buf_wr && !full) begin
			msg_len <= msg_len + 8'd1;
		end
	end

	// byte 0 in the low bits, as on the transmit side
	always_ff @(posedge sys_clk) begin
		if (buf_wr && !buf_clr && !full) begin
			msg[int'(msg_len) * 8 +: 8] <= buf_byte;
		end
	end

endmodule

// ==== verilog/uart_rx_phy.sv ====
/*
 * uart_rx_phy
 * two-flop line synchronizer and mid-bit sampler; deserializes one byte
 * per frame and flags a low stop bit
 */
`timescale 1ns/10ps

module uart_rx_phy #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                rxd,
	output str_link_pkg::byte_t rx_data,
	output logic                rx_vld,
	output logic                rx_ferr
);

	localparam int CW   = $clog2(CLKS_PER_BIT + 1);
	localparam int HALF = CLKS_PER_BIT / 2;

	typedef enum logic [1:0] {
		RS_IDLE,
		RS_START,
		RS_DATA,
		RS_STOP
	} rs_state_t;

	rs_state_t     state;
	logic          rx_meta;
	logic          rx_sync;
	logic          rx_prev;
	logic [CW-1:0] cnt;
	logic [2:0]    bit_cnt;
	logic          bit_mid;

	assign bit_mid = (cnt == CW'(CLKS_PER_BIT - 1));

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= RS_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
			rx_ferr <= 1'b0;
		end else begin
			rx_vld  <= 1'b0;
			rx_ferr <= 1'b0;
			case (state)
				RS_IDLE: begin
					// falling edge of the start bit
					if (rx_prev && !rx_sync) begin
						state <= RS_START;
						cnt   <= '0;
					end
				end
				RS_START: begin
					if (cnt == CW'(HALF - 1)) begin
						cnt     <= '0;
						bit_cnt <= '0;
						// a glitch shorter than half a bit is ignored
						state   <= rx_sync ? RS_IDLE : RS_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RS_DATA: begin
					if (bit_mid) begin
						cnt <= '0;
						if (bit_cnt == 3'd7) begin
							state <= RS_STOP;
						end
						bit_cnt <= bit_cnt + 3'd1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RS_STOP: begin
					if (bit_mid) begin
						cnt     <= '0;
						rx_vld  <= rx_sync;
						rx_ferr <= !rx_sync;
						state   <= RS_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RS_DATA && bit_mid) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

endmodule

// ==== verilog/uart_tx_phy.sv ====
/*
 * uart_tx_phy
 * byte serializer: start bit, eight data bits LSB first, one stop bit
 */
`timescale 1ns/10ps

module uart_tx_phy #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	uart_byte_if.phy byte_if,
	output logic     txd
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	logic [CW-1:0] baud_cnt;
	logic [3:0]    bit_cnt;
	logic [8:0]    shift_q;
	logic          bit_end;

	assign bit_end = (baud_cnt == CW'(CLKS_PER_BIT - 1));

	// bit 0 is the start bit, bit 9 the stop bit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			txd          <= 1'b1;
			byte_if.busy <= 1'b0;
			byte_if.done <= 1'b0;
			baud_cnt     <= '0;
			bit_cnt      <= '0;
		end else begin
			byte_if.done <= 1'b0;
			if (!byte_if.busy) begin
				if (byte_if.req) begin
					txd          <= 1'b0;
					byte_if.busy <= 1'b1;
					baud_cnt     <= '0;
					bit_cnt      <= '0;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					byte_if.busy <= 1'b0;
					byte_if.done <= 1'b1;
				end else begin
					// after eight shifts the filled-in one gives the stop bit
					txd     <= shift_q[0];
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// data bits with the stop level behind them
	always_ff @(posedge sys_clk) begin
		if (!byte_if.busy && byte_if.req) begin
			shift_q <= {1'b1, byte_if.data};
		end else if (byte_if.busy && bit_end && bit_cnt != 4'd9) begin
			shift_q <= {1'b1, shift_q[8:1]};
		end
	end

endmodule

// ==== verilog/uart_byte_if.sv ====
/*
 * uart_byte_if
 * byte handshake between the frame controller and the UART transmitter
 */
`timescale 1ns/10ps

interface uart_byte_if;

	// byte to send, held by the controller until done
	str_link_pkg::byte_t data;

	// one-cycle request, only while busy is low
	logic req;

	// one cycle after the stop bit
	logic done;

	logic busy;

	modport ctrl (
		output data,
		output req,
		input  done,
		input  busy
	);

	modport phy (
		input  data,
		input  req,
		output done,
		output busy
	);

endinterface

// ==== verilog/str_link_pkg.sv ====
/*
 * str_link_pkg
 * shared line byte type, frame delimiter and the framer/deframer
 * state encodings of the framed string link
 */
package str_link_pkg;

	// one character on the serial line
	typedef logic [7:0] byte_t;

	// sent twice to open and twice to close a frame
	localparam byte_t DELIM_CHAR = 8'h26;

	// transmit framer
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_DLM1,
		TX_DLM2,
		TX_CONTENT,
		TX_DLM3,
		TX_DLM4,
		TX_FINISH
	} tx_state_t;

	// receive deframer
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_OPEN1,
		RX_CONTENT,
		RX_CLOSE1,
		RX_DELIVER
	} rx_state_t;

endpackage
